//--- src/udp_rx_pkg.sv
package udp_rx_pkg;

    // ========================================
    // Protocol constants
    // ========================================
    localparam int beat_bytes            = 32;
    localparam int udp_hdr_bytes         = 8;
    // Payload bytes that share beat 1 with the IP tail and the UDP header
    localparam int first_payload_bytes   = 22;
    localparam int default_payload_bytes = 54;

    localparam logic [7:0] udp_protocol = 8'd17;
    localparam logic [3:0] ipv4_version = 4'd4;

    typedef logic [5:0][7:0] mac_addr_t;
    typedef logic [31:0]     ipv4_addr_t;

    localparam mac_addr_t broadcast_mac = '1;

    // ========================================
    // Header layouts, first byte on the wire in the top bits
    // ========================================
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        logic [15:0] ether_len;
    } eth_hdr_t;

    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_checksum;
        ipv4_addr_t  src_ip;
        ipv4_addr_t  dest_ip;
    } ipv4_hdr_t;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] udp_len;
        logic [15:0] checksum;
    } udp_hdr_t;

    // Payload byte i sits at payload[8*i +: 8]; unused bytes read as zero
    typedef struct packed {
        eth_hdr_t                               eth;
        ipv4_hdr_t                              ip;
        udp_hdr_t                               udp;
        logic [default_payload_bytes*8-1:0]     payload;
        logic [15:0]                            payload_bytes;
        logic                                   overflow;
    } rx_frame_t;

    typedef struct packed {
        ipv4_addr_t                         src_ip;
        logic [15:0]                        src_port;
        ipv4_addr_t                         dest_ip;
        logic [15:0]                        dest_port;
        logic [default_payload_bytes*8-1:0] payload;
        logic [15:0]                        payload_bytes;
    } rx_msg_t;

    typedef struct packed {
        logic mac;
        logic ip;
        logic proto;
        logic version;
        logic length;
    } drop_reason_t;

    // ========================================
    // State and select encodings
    // ========================================
    typedef enum logic [2:0] {
        st_accepted,
        st_dropped,
        st_mac,
        st_ip,
        st_proto,
        st_version,
        st_length,
        st_framing
    } stat_sel_e;

    typedef enum logic [1:0] {
        idle,
        header_tail,
        payload
    } parse_state_e;

    typedef enum logic {
        read_idle,
        read_ack
    } read_state_e;

endpackage

//--- src/rx_frame_parser.sv
`timescale 1ns/1ns

module rx_frame_parser
    import udp_rx_pkg::*;
#(
    parameter int MAX_PAYLOAD_BYTES = default_payload_bytes
) (
    input  logic         rx_clk_in,
    input  logic         rx_reset_in,
    input  logic [255:0] rx_data,
    input  logic         rx_valid,
    input  logic         rx_sop,
    input  logic         rx_eop,
    input  logic [4:0]   rx_empty,
    output rx_frame_t    frame,
    output logic         frame_done,
    output logic         framing_error
);

    parse_state_e state, state_next;

    // Frame being assembled, copied to the output one edge after eop
    rx_frame_t work, work_next;
    logic      done_pending, done_next;
    logic      error_next;

    logic [5:0] beat_base;
    logic [5:0] beat_count;
    logic       beat_over;
    logic [default_payload_bytes*8-1:0] placed;

    // ========================================
    // Payload bytes carried by this beat
    // ========================================
    always_comb begin
        if (state == header_tail) begin
            beat_base  = 6'(beat_bytes - first_payload_bytes);
            beat_count = 6'(first_payload_bytes);
        end else begin
            beat_base  = 6'd0;
            beat_count = 6'(beat_bytes);
        end
        // Empty bytes only count on the eop beat
        if (rx_eop) begin
            if ({1'b0, rx_empty} > beat_count) begin
                beat_count = 6'd0;
            end else begin
                beat_count = beat_count - {1'b0, rx_empty};
            end
        end
    end

    // Drop each beat byte into the payload at the running offset
    always_comb begin
        int rel;
        placed = work.payload;
        for (int k = 0; k < MAX_PAYLOAD_BYTES; k++) begin
            rel = k - int'(work.payload_bytes);
            if (rel >= 0 && rel < int'(beat_count)) begin
                placed[8*k +: 8] = rx_data[8*(31 - rel - int'(beat_base)) +: 8];
            end
        end
    end

    // Anything past the capacity is lost
    assign beat_over = (int'(work.payload_bytes) + int'(beat_count)) > MAX_PAYLOAD_BYTES;

    // ========================================
    // Parse FSM
    // ========================================
    always_comb begin
        state_next = state;
        work_next  = work;
        done_next  = 1'b0;
        error_next = 1'b0;

        if (rx_valid) begin
            if (rx_sop) begin
                // Restart mid-frame, or a frame too short to hold the headers
                error_next = (state != idle) || rx_eop;
                if (rx_eop) begin
                    state_next = idle;
                end else begin
                    work_next.eth           = rx_data[255:144];
                    work_next.ip[159:16]    = rx_data[143:0];
                    work_next.payload       = '0;
                    work_next.payload_bytes = 16'd0;
                    work_next.overflow      = 1'b0;
                    state_next              = header_tail;
                end
            end else if (state == idle) begin
                // Stray beat outside a frame
                error_next = 1'b1;
            end else begin
                if (state == header_tail) begin
                    work_next.ip[15:0] = rx_data[255:240];
                    work_next.udp      = rx_data[239:176];
                end
                work_next.payload       = placed;
                work_next.payload_bytes = work.payload_bytes + 16'(beat_count);
                work_next.overflow      = work.overflow | beat_over;

                if (rx_eop) begin
                    done_next  = 1'b1;
                    state_next = idle;
                end else begin
                    state_next = payload;
                end
            end
        end
    end

    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            state         <= idle;
            done_pending  <= 1'b0;
            frame_done    <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            state         <= state_next;
            done_pending  <= done_next;
            frame_done    <= done_pending;
            framing_error <= error_next;
        end
    end

    // A new sop may land on the same edge as the copy, old contents win
    always_ff @(posedge rx_clk_in) begin
        work <= work_next;
        if (done_pending) begin
            frame <= work;
        end
    end

endmodule

//--- src/rx_header_filter.sv
`timescale 1ns/1ns

module rx_header_filter
    import udp_rx_pkg::*;
#(
    parameter int MAX_PAYLOAD_BYTES = default_payload_bytes
) (
    input  logic         rx_clk_in,
    input  logic         rx_reset_in,
    input  mac_addr_t    host_mac,
    input  ipv4_addr_t   host_ip,
    input  rx_frame_t    frame,
    input  logic         frame_done,
    output rx_msg_t      msg,
    output logic         msg_valid,
    output drop_reason_t reasons,
    output logic         dropped,
    output logic         accepted
);

    drop_reason_t flags;
    logic [15:0]  udp_data_len;
    rx_msg_t      msg_next;

    // ========================================
    // Header checks
    // ========================================
    assign udp_data_len = frame.udp.udp_len - 16'(udp_hdr_bytes);

    always_comb begin
        flags.mac = (frame.eth.dest_mac != broadcast_mac) &&
                    (frame.eth.dest_mac != host_mac);
        flags.ip      = frame.ip.dest_ip != host_ip;
        flags.proto   = frame.ip.protocol != udp_protocol;
        flags.version = frame.ip.version != ipv4_version;
        flags.length  = frame.overflow || (udp_data_len != frame.payload_bytes);
    end

    // Decision goes to the counters in the slot where msg_valid is formed
    assign reasons  = frame_done ? flags : '0;
    assign dropped  = frame_done && (|flags);
    assign accepted = frame_done && !(|flags);

    // ========================================
    // Message build and output register
    // ========================================
    always_comb begin
        msg_next               = '0;
        msg_next.src_ip        = frame.ip.src_ip;
        msg_next.src_port      = frame.udp.src_port;
        msg_next.dest_ip       = frame.ip.dest_ip;
        msg_next.dest_port     = frame.udp.dest_port;
        msg_next.payload_bytes = frame.payload_bytes;
        msg_next.payload[MAX_PAYLOAD_BYTES*8-1:0] = frame.payload[MAX_PAYLOAD_BYTES*8-1:0];
    end

    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= accepted;
        end
    end

    always_ff @(posedge rx_clk_in) begin
        if (accepted) begin
            msg <= msg_next;
        end
    end

endmodule

//--- src/rx_stat_counters.sv
`timescale 1ns/1ns

module rx_stat_counters
    import udp_rx_pkg::*;
#(
    parameter int CNT_WIDTH = 32
) (
    input  logic                 rx_clk_in,
    input  logic                 rx_reset_in,
    input  drop_reason_t         reasons,
    input  logic                 dropped,
    input  logic                 accepted,
    input  logic                 framing_error,
    input  logic                 stat_req,
    input  stat_sel_e            stat_sel,
    output logic                 stat_ack,
    output logic [CNT_WIDTH-1:0] stat_data
);

    localparam int num_counts = 8;

    logic [CNT_WIDTH-1:0]  counts [num_counts];
    logic [num_counts-1:0] inc;
    read_state_e           read_state;

    // ========================================
    // Event to counter mapping
    // ========================================
    always_comb begin
        inc              = '0;
        inc[st_accepted] = accepted;
        // A frame with several faults still counts as one drop
        inc[st_dropped]  = dropped;
        inc[st_mac]      = reasons.mac;
        inc[st_ip]       = reasons.ip;
        inc[st_proto]    = reasons.proto;
        inc[st_version]  = reasons.version;
        inc[st_length]   = reasons.length;
        inc[st_framing]  = framing_error;
    end

    // Saturating counters
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            for (int i = 0; i < num_counts; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_counts; i++) begin
                if (inc[i] && (counts[i] != '1)) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

    // ========================================
    // Four-phase read port
    // ========================================
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            read_state <= read_idle;
        end else begin
            case (read_state)
                read_idle: begin
                    if (stat_req) begin
                        read_state <= read_ack;
                    end
                end
                read_ack: begin
                    // Hold ack until the requester lets go
                    if (!stat_req) begin
                        read_state <= read_idle;
                    end
                end
                default: begin
                    read_state <= read_idle;
                end
            endcase
        end
    end

    // Snapshot taken on the request edge, stable while ack is high
    always_ff @(posedge rx_clk_in) begin
        if (read_state == read_idle && stat_req) begin
            stat_data <= counts[stat_sel];
        end
    end

    assign stat_ack = (read_state == read_ack);

endmodule

//--- src/udp_rx_top.sv
`timescale 1ns/1ns

module udp_rx_top
    import udp_rx_pkg::*;
#(
    parameter int MAX_PAYLOAD_BYTES = default_payload_bytes,
    parameter int CNT_WIDTH         = 32
) (
    input  logic                 rx_clk_in,
    input  logic                 rx_reset_in,

    // Avalon-ST receive beats
    input  logic [255:0]         rx_data,
    input  logic                 rx_valid,
    input  logic                 rx_sop,
    input  logic                 rx_eop,
    input  logic [4:0]           rx_empty,

    // Static host addresses
    input  mac_addr_t            host_mac,
    input  ipv4_addr_t           host_ip,

    output rx_msg_t              msg,
    output logic                 msg_valid,

    // Counter read port
    input  logic                 stat_req,
    input  stat_sel_e            stat_sel,
    output logic                 stat_ack,
    output logic [CNT_WIDTH-1:0] stat_data
);

    rx_frame_t    frame;
    logic         frame_done;
    logic         framing_error;
    drop_reason_t reasons;
    logic         dropped;
    logic         accepted;

    rx_frame_parser #(
        .MAX_PAYLOAD_BYTES(MAX_PAYLOAD_BYTES)
    ) u_parser (
        .rx_clk_in    (rx_clk_in),
        .rx_reset_in  (rx_reset_in),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_sop       (rx_sop),
        .rx_eop       (rx_eop),
        .rx_empty     (rx_empty),
        .frame        (frame),
        .frame_done   (frame_done),
        .framing_error(framing_error)
    );

    rx_header_filter #(
        .MAX_PAYLOAD_BYTES(MAX_PAYLOAD_BYTES)
    ) u_filter (
        .rx_clk_in  (rx_clk_in),
        .rx_reset_in(rx_reset_in),
        .host_mac   (host_mac),
        .host_ip    (host_ip),
        .frame      (frame),
        .frame_done (frame_done),
        .msg        (msg),
        .msg_valid  (msg_valid),
        .reasons    (reasons),
        .dropped    (dropped),
        .accepted   (accepted)
    );

    rx_stat_counters #(
        .CNT_WIDTH(CNT_WIDTH)
    ) u_counters (
        .rx_clk_in    (rx_clk_in),
        .rx_reset_in  (rx_reset_in),
        .reasons      (reasons),
        .dropped      (dropped),
        .accepted     (accepted),
        .framing_error(framing_error),
        .stat_req     (stat_req),
        .stat_sel     (stat_sel),
        .stat_ack     (stat_ack),
        .stat_data    (stat_data)
    );

endmodule

//--- tb/udp_rx_tb.sv
`timescale 1ns/1ns

module udp_rx_tb
    import udp_rx_pkg::*;
();

    localparam mac_addr_t  host_mac_c = 48'h02_00_5e_10_20_30;
    localparam ipv4_addr_t host_ip_c  = 32'h0a00_0001;

    // Packet record, payload byte i at data[8*i +: 8]
    typedef struct packed {
        mac_addr_t   dest_mac;
        ipv4_addr_t  src_ip;
        ipv4_addr_t  dest_ip;
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [7:0]  protocol;
        logic [3:0]  version;
        logic [15:0] udp_len;
        logic [15:0] len;
        logic [511:0] data;
    } pkt_t;

    logic         rx_clk_in;
    logic         rx_reset_in;
    logic [255:0] rx_data;
    logic         rx_valid;
    logic         rx_sop;
    logic         rx_eop;
    logic [4:0]   rx_empty;
    rx_msg_t      msg;
    logic         msg_valid;
    logic         stat_req;
    stat_sel_e    stat_sel;
    logic         stat_ack;
    logic [31:0]  stat_data;

    logic [31:0] seed = 32'hcf36;
    int          cycle = 0;
    int          last_drive_cycle;
    int          errors = 0;
    int          checks = 0;
    int          exp_cnt [8];
    rx_msg_t     exp_q [$];
    int          cyc_q [$];
    pkt_t        p;

    udp_rx_top #(
        .MAX_PAYLOAD_BYTES(54),
        .CNT_WIDTH        (32)
    ) UUT (
        .rx_clk_in  (rx_clk_in),
        .rx_reset_in(rx_reset_in),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_sop     (rx_sop),
        .rx_eop     (rx_eop),
        .rx_empty   (rx_empty),
        .host_mac   (host_mac_c),
        .host_ip    (host_ip_c),
        .msg        (msg),
        .msg_valid  (msg_valid),
        .stat_req   (stat_req),
        .stat_sel   (stat_sel),
        .stat_ack   (stat_ack),
        .stat_data  (stat_data)
    );

    always #20 rx_clk_in = ~rx_clk_in;

    always @(posedge rx_clk_in) cycle <= cycle + 1;

    // ========================================
    // Helpers
    // ========================================
    function logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic compare_value(input string what, input logic [599:0] got,
                                 input logic [599:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string why);
        errors++;
        $display("timeout at %0t: %s", $time, why);
    endtask

    function automatic pkt_t make_pkt(input int len);
        pkt_t q;
        q           = '0;
        q.dest_mac  = host_mac_c;
        q.src_ip    = lcg_next();
        q.dest_ip   = host_ip_c;
        q.src_port  = 16'(lcg_next());
        q.dest_port = 16'(lcg_next());
        q.protocol  = 8'd17;
        q.version   = 4'd4;
        q.udp_len   = 16'(len + 8);
        q.len       = 16'(len);
        for (int i = 0; i < len; i++) begin
            q.data[8*i +: 8] = 8'(lcg_next() >> 24);
        end
        return q;
    endfunction

    // Expected flags, and the message when nothing is flagged
    function automatic drop_reason_t model_frame(input pkt_t q, output rx_msg_t m);
        drop_reason_t f;
        m               = '0;
        m.src_ip        = q.src_ip;
        m.src_port      = q.src_port;
        m.dest_ip       = q.dest_ip;
        m.dest_port     = q.dest_port;
        m.payload_bytes = q.len;
        for (int i = 0; i < 54 && i < int'(q.len); i++) begin
            m.payload[8*i +: 8] = q.data[8*i +: 8];
        end
        f.mac     = (q.dest_mac != 48'hffff_ffff_ffff) && (q.dest_mac != host_mac_c);
        f.ip      = q.dest_ip != host_ip_c;
        f.proto   = q.protocol != 8'd17;
        f.version = q.version != 4'd4;
        f.length  = (q.len > 16'd54) || (q.udp_len - 16'd8 != q.len);
        return f;
    endfunction

    task automatic record_expected(input pkt_t q);
        drop_reason_t f;
        rx_msg_t      m;
        f = model_frame(q, m);
        if (f == '0) begin
            exp_q.push_back(m);
            // eop sampled one edge after it is driven, message seen three edges later
            cyc_q.push_back(last_drive_cycle + 4);
            exp_cnt[st_accepted]++;
        end else begin
            exp_cnt[st_dropped]++;
            exp_cnt[st_mac]     += f.mac;
            exp_cnt[st_ip]      += f.ip;
            exp_cnt[st_proto]   += f.proto;
            exp_cnt[st_version] += f.version;
            exp_cnt[st_length]  += f.length;
        end
    endtask

    // ========================================
    // Beat drivers
    // ========================================
    task automatic send_beat(input logic [255:0] d, input logic sop, input logic eop,
                             input int empty);
        @(posedge rx_clk_in);
        last_drive_cycle = cycle;
        rx_data  <= d;
        rx_valid <= 1'b1;
        rx_sop   <= sop;
        rx_eop   <= eop;
        rx_empty <= 5'(empty);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge rx_clk_in);
            rx_valid <= 1'b0;
            rx_sop   <= 1'b0;
            rx_eop   <= 1'b0;
        end
    endtask

    function automatic logic [255:0] rand_beat();
        logic [255:0] d;
        for (int i = 0; i < 8; i++) begin
            d[32*i +: 32] = lcg_next();
        end
        return d;
    endfunction

    task automatic send_frame(input pkt_t q);
        eth_hdr_t     eth;
        ipv4_hdr_t    ip;
        udp_hdr_t     udp;
        logic [335:0] hdr;
        logic [7:0]   stream [128];
        logic [255:0] beat;
        int           total;
        int           nbeats;
        eth           = '0;
        eth.dest_mac  = q.dest_mac;
        eth.src_mac   = 48'h0a_0b_0c_0d_0e_0f;
        eth.ether_len = 16'h0800;
        ip            = '0;
        ip.version    = q.version;
        ip.ihl        = 4'd5;
        ip.total_len  = q.len + 16'd28;
        ip.ttl        = 8'd64;
        ip.protocol   = q.protocol;
        ip.src_ip     = q.src_ip;
        ip.dest_ip    = q.dest_ip;
        udp           = '0;
        udp.src_port  = q.src_port;
        udp.dest_port = q.dest_port;
        udp.udp_len   = q.udp_len;
        hdr           = {eth, ip, udp};
        total         = 42 + int'(q.len);
        nbeats        = (total + 31) / 32;
        for (int j = 0; j < 128; j++) begin
            stream[j] = (j < 42) ? hdr[8*(41-j) +: 8] : 8'h00;
        end
        for (int j = 0; j < int'(q.len); j++) begin
            stream[42+j] = q.data[8*j +: 8];
        end
        for (int k = 0; k < nbeats; k++) begin
            for (int b = 0; b < 32; b++) begin
                beat[8*(31-b) +: 8] = stream[32*k + b];
            end
            send_beat(beat, k == 0, k == nbeats - 1, (k == nbeats - 1) ? nbeats*32 - total : 0);
        end
        record_expected(q);
    endtask

    // Four-phase counter read
    task automatic read_stat(input stat_sel_e sel);
        int t;
        @(posedge rx_clk_in);
        stat_req <= 1'b1;
        stat_sel <= sel;
        t = 0;
        while (stat_ack !== 1'b1 && t < 20) begin
            @(posedge rx_clk_in);
            t++;
        end
        if (stat_ack !== 1'b1) begin
            report_timeout("stat_ack never rose after stat_req");
        end else begin
            compare_value(sel.name(), stat_data, exp_cnt[sel]);
        end
        stat_req <= 1'b0;
        t = 0;
        while (stat_ack !== 1'b0 && t < 20) begin
            @(posedge rx_clk_in);
            t++;
        end
        if (stat_ack !== 1'b0) begin
            report_timeout("stat_ack stayed high after stat_req fell");
        end
    endtask

    // Comparator
    always @(posedge rx_clk_in) begin
        if (msg_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected message at %0t with no accepted frame pending", $time);
            end else begin
                compare_value("message", msg, exp_q.pop_front());
                compare_value("arrival cycle", cycle, cyc_q.pop_front());
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        int t;
        rx_clk_in   = 1'b0;
        rx_reset_in = 1'b1;
        rx_data     = '0;
        rx_valid    = 1'b0;
        rx_sop      = 1'b0;
        rx_eop      = 1'b0;
        rx_empty    = '0;
        stat_req    = 1'b0;
        stat_sel    = st_accepted;
        for (int i = 0; i < 8; i++) exp_cnt[i] = 0;
        repeat (4) @(posedge rx_clk_in);
        rx_reset_in <= 1'b0;
        idle_cycles(2);
        compare_value("msg_valid after reset", msg_valid, 1'b0);
        compare_value("stat_ack after reset", stat_ack, 1'b0);

        // Good frames across the beat boundaries
        send_frame(make_pkt(1));
        send_frame(make_pkt(22));
        send_frame(make_pkt(23));
        p = make_pkt(54);
        p.dest_mac = '1;
        send_frame(p);
        idle_cycles(3);

        // Single and double header faults
        p = make_pkt(10);
        p.dest_mac = 48'h02_00_00_00_00_99;
        send_frame(p);
        p = make_pkt(30);
        p.dest_ip = host_ip_c ^ 32'h1;
        send_frame(p);
        p = make_pkt(5);
        p.protocol = 8'd6;
        send_frame(p);
        p = make_pkt(40);
        p.version = 4'd6;
        send_frame(p);
        p = make_pkt(12);
        p.dest_mac = 48'h02_00_00_00_00_77;
        p.dest_ip  = 32'hc0a8_0001;
        send_frame(p);
        p = make_pkt(20);
        p.udp_len = p.udp_len + 16'd1;
        send_frame(p);
        send_frame(make_pkt(60));
        idle_cycles(2);

        // Restart mid-frame, then a stray beat in idle
        send_beat(rand_beat(), 1'b1, 1'b0, 0);
        exp_cnt[st_framing]++;
        send_frame(make_pkt(33));
        idle_cycles(2);
        send_beat(rand_beat(), 1'b0, 1'b0, 0);
        exp_cnt[st_framing]++;
        idle_cycles(2);
        send_frame(make_pkt(17));

        // Random back-to-back frames
        repeat (12) begin
            p = make_pkt(int'(lcg_next() % 54) + 1);
            case (lcg_next() % 6)
                0: p.dest_mac = 48'h02_00_00_00_00_55;
                1: p.protocol = 8'd1;
                default: ;
            endcase
            send_frame(p);
        end
        idle_cycles(8);

        t = 0;
        while (exp_q.size() != 0 && t < 50) begin
            @(posedge rx_clk_in);
            t++;
        end
        if (exp_q.size() != 0) begin
            report_timeout("expected messages never arrived");
        end

        for (int s = 0; s < 8; s++) begin
            read_stat(stat_sel_e'(s));
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
src/udp_rx_pkg.sv
src/rx_frame_parser.sv
src/rx_header_filter.sv
src/rx_stat_counters.sv
src/udp_rx_top.sv
tb/udp_rx_tb.sv
